//--- common/mem_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if
    import mmio_pkg::*;
();

    // read side
    logic [addr_width-1:0] raddr;
    logic                  ren;

    // write side
    logic [addr_width-1:0] waddr;
    logic [reg_width-1:0]  wdata;
    logic                  wen;
    logic [size_width-1:0] size;

    // core side fills the bus
    modport drv (
        output raddr,
        output ren,
        output waddr,
        output wdata,
        output wen,
        output size
    );

    // ram, write decoder and read combiner only look
    modport dev (
        input raddr,
        input ren,
        input waddr,
        input wdata,
        input wen,
        input size
    );

endinterface

`default_nettype wire

//--- common/mmio_pkg.sv
`default_nettype none

package mmio_pkg;

    // datapath widths
    localparam int reg_width  = 64;
    localparam int addr_width = 64;
    localparam int size_width = 4;
    localparam int kb_width   = 8;
    localparam int swt_width  = 8;
    localparam int seg_width  = 32;
    localparam int led_width  = 16;

    // bit positions inside the one-hot write size
    localparam int size_byte  = 0;
    localparam int size_half  = 1;
    localparam int size_word  = 2;
    localparam int size_dword = 3;

    // byte lanes of one doubleword
    localparam int lane_cnt   = reg_width / 8;
    localparam int lane_width = $clog2(lane_cnt);

    // data ram region
    localparam logic [addr_width-1:0] ram_base = 64'h0000_0000_8000_0000;
    localparam logic [addr_width-1:0] ram_len  = 64'd4096;

    // ram is organized in doublewords
    localparam int ram_depth     = int'(ram_len / lane_cnt);
    localparam int ram_idx_width = $clog2(ram_depth);

    // keyboard and clock-divider counter
    localparam logic [addr_width-1:0] kbd_base = 64'h0000_0000_a000_0060;
    localparam logic [addr_width-1:0] kbd_len  = 64'd8;
    localparam logic [addr_width-1:0] rtc_base = 64'h0000_0000_a000_0048;
    localparam logic [addr_width-1:0] rtc_len  = 64'd8;

    // small peripherals, all share one region length
    localparam logic [addr_width-1:0] swt_base = 64'h0000_0000_a000_0100;
    localparam logic [addr_width-1:0] seg_base = 64'h0000_0000_a000_0200;
    localparam logic [addr_width-1:0] led_base = 64'h0000_0000_a000_0300;
    localparam logic [addr_width-1:0] peri_len = 64'd8;

    // base is inclusive, base + len is exclusive
    function automatic logic in_region(
        input logic [addr_width-1:0] addr,
        input logic [addr_width-1:0] base,
        input logic [addr_width-1:0] len
    );
        return (addr >= base) && (addr < (base + len));
    endfunction

endpackage

`default_nettype wire

//--- data_ram/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram
    import mmio_pkg::*;
(
    input  logic                 clk,
    mem_bus_if.dev               bus,
    output logic [reg_width-1:0] ram_rdata
);

    logic [reg_width-1:0] mem [ram_depth];

    logic [ram_idx_width-1:0] wr_idx;
    logic [ram_idx_width-1:0] rd_idx;
    logic [lane_width-1:0]    wr_lane;
    logic                     wr_hit;
    logic [lane_cnt-1:0]      size_mask;
    logic [lane_cnt-1:0]      lane_mask;
    logic [reg_width-1:0]     lane_data;

    // doubleword index sits above the byte offset
    assign wr_idx  = bus.waddr[lane_width +: ram_idx_width];
    assign rd_idx  = bus.raddr[lane_width +: ram_idx_width];
    assign wr_lane = bus.waddr[lane_width-1:0];

    assign wr_hit = bus.wen && in_region(bus.waddr, ram_base, ram_len);

    // bytes covered by the access before lane alignment
    always_comb begin
        case (1'b1)
            bus.size[size_byte]: begin
                size_mask = lane_cnt'(1);
            end
            bus.size[size_half]: begin
                size_mask = lane_cnt'(3);
            end
            bus.size[size_word]: begin
                size_mask = lane_cnt'(15);
            end
            bus.size[size_dword]: begin
                size_mask = '1;
            end
            default: begin
                size_mask = '0;
            end
        endcase
    end

    // move the low bytes of wdata up to the addressed lane
    // bytes pushed past the top lane are dropped
    assign lane_mask = size_mask << wr_lane;
    assign lane_data = bus.wdata << {wr_lane, 3'b000};

    always_ff @(posedge clk) begin
        if (wr_hit) begin
            for (int i = 0; i < lane_cnt; i++) begin
                if (lane_mask[i]) begin
                    mem[wr_idx][i*8 +: 8] <= lane_data[i*8 +: 8];
                end
            end
        end
    end

    // whole aligned doubleword, old contents on a same-cycle write
    assign ram_rdata = mem[rd_idx];

    // a write must name exactly one access size
    wen_size_onehot: assert property (
        @(posedge clk) bus.wen |-> $onehot(bus.size)
    );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build the mmio testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_mmio \
    -f src.f \
    && ./obj_dir/Vtb_mmio | tee /dev/stderr | grep -q "TEST PASSED" \
    && echo "run.sh: simulation ok" \
    || { echo "run.sh: simulation failed"; exit 1; }

//--- src.f
+incdir+test
common/mmio_pkg.sv
common/mem_bus_if.sv
data_ram/data_ram.sv
verilog/periph_regs.sv
verilog/read_mux.sv
verilog/mmio_top.sv
test/tb_mmio.sv

//--- test/tb_mmio_tasks.svh
// reference model of the data ram, one entry per doubleword
logic [reg_width-1:0] ram_model [ram_depth];

logic [63:0] rng_state = 64'd72;

// display values the DUT should hold
logic [seg_width-1:0] seg_expect = '0;
logic [led_width-1:0] led_expect = '0;

// xorshift64
function automatic logic [63:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 7);
    rng_state = rng_state ^ (rng_state << 17);
    return rng_state;
endfunction

function automatic logic [addr_width-1:0] ram_addr(
    input logic [ram_idx_width-1:0] idx,
    input logic [lane_width-1:0]    lane
);
    return ram_base + {{(addr_width-ram_idx_width-lane_width){1'b0}}, idx, lane};
endfunction

// low 2**sz bytes of data land at the lane, other lanes keep their bytes
function automatic void model_write(
    input logic [ram_idx_width-1:0] idx,
    input logic [lane_width-1:0]    lane,
    input int                       sz,
    input logic [reg_width-1:0]     data
);
    int nbytes;
    nbytes = 1 << sz;
    for (int b = 0; b < nbytes; b++) begin
        ram_model[idx][(int'(lane) + b) * 8 +: 8] = data[b * 8 +: 8];
    end
endfunction

task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
endtask

task automatic check_word(input string name, input logic [reg_width-1:0] expected,
                          input logic [reg_width-1:0] actual);
    if (actual !== expected) begin
        $display("Error: %s expected %h, got %h", name, expected, actual);
        abort_run();
    end
endtask

task automatic check_seg(input string name, input logic [seg_width-1:0] expected,
                         input logic [seg_width-1:0] actual);
    if (actual !== expected) begin
        $display("Error: %s expected %h, got %h", name, expected, actual);
        abort_run();
    end
endtask

task automatic check_led(input string name, input logic [led_width-1:0] expected,
                         input logic [led_width-1:0] actual);
    if (actual !== expected) begin
        $display("Error: %s expected %h, got %h", name, expected, actual);
        abort_run();
    end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("Error: %s expected %h, got %h", name, expected, actual);
        abort_run();
    end
endtask

// wen high for one cycle, the write lands on the edge this task returns at
task automatic write_bus(input logic [addr_width-1:0] addr, input logic [reg_width-1:0] data,
                         input logic [size_width-1:0] size);
    @(posedge clk);
    mem_waddr <= addr;
    mem_wdata <= data;
    wdt_op    <= size;
    mem_wen   <= 1'b1;
    @(posedge clk);
    mem_wen <= 1'b0;
endtask

// combinational result sampled mid-cycle
task automatic read_bus(input logic [addr_width-1:0] addr, output logic [reg_width-1:0] data,
                        output logic strobe);
    @(posedge clk);
    mem_raddr <= addr;
    mem_ren   <= 1'b1;
    @(negedge clk);
    data   = mem_rdata;
    strobe = sig_rd_kb;
    @(posedge clk);
    mem_ren <= 1'b0;
endtask

task automatic set_kbd(input logic [kb_width-1:0] data, input logic ready);
    @(posedge clk);
    kb_rdata <= data;
    kb_ready <= ready;
endtask

task automatic set_misc(input logic [swt_width-1:0] swt, input logic [reg_width-1:0] div);
    @(posedge clk);
    swt_rdata <= swt;
    clkdiv    <= div;
endtask

task automatic check_reset_state();
    @(negedge clk);
    check_bit("rd_fault", 1'b0, rd_fault);
    check_bit("wr_fault", 1'b0, wr_fault);
    check_bit("sig_rd_kb", 1'b0, sig_rd_kb);
    check_seg("seg_wdata", '0, seg_wdata);
    check_led("led_wdata", '0, led_wdata);
    check_word("mem_rdata", '0, mem_rdata);
endtask

task automatic test_ram_subword();
    logic [ram_idx_width-1:0] slot_idx [ram_slots];
    logic [63:0]              rnd;
    logic [reg_width-1:0]     data;
    logic [reg_width-1:0]     rdata;
    logic [lane_width-1:0]    lane;
    logic                     strobe;
    int                       sz;
    int                       s;
    // full doublewords first so every byte is known
    for (int i = 0; i < ram_slots; i++) begin
        rnd = next_rand();
        slot_idx[i] = rnd[ram_idx_width-1:0];
        data = next_rand();
        write_bus(ram_addr(slot_idx[i], '0), data, dword_op);
        model_write(slot_idx[i], '0, size_dword, data);
    end
    // random size, lane aligned to the size
    for (int i = 0; i < ram_writes; i++) begin
        rnd = next_rand();
        s = int'(rnd[2:0]) % ram_slots;
        sz = int'(rnd[4:3]);
        lane = (rnd[7:5] >> sz) << sz;
        data = next_rand();
        write_bus(ram_addr(slot_idx[s], lane), data, size_width'(1) << sz);
        model_write(slot_idx[s], lane, sz, data);
    end
    for (int i = 0; i < ram_slots; i++) begin
        rnd = next_rand();
        read_bus(ram_addr(slot_idx[i], rnd[2:0]), rdata, strobe);
        check_word("mem_rdata", ram_model[slot_idx[i]], rdata);
        check_bit("sig_rd_kb", 1'b0, strobe);
    end
endtask

task automatic test_seg_led();
    logic [reg_width-1:0] data;
    data = next_rand();
    write_bus(seg_base, data, dword_op);
    seg_expect = data[seg_width-1:0];
    @(negedge clk);
    check_seg("seg_wdata", seg_expect, seg_wdata);
    check_led("led_wdata", led_expect, led_wdata);
    data = next_rand();
    write_bus(led_base + 64'd4, data, dword_op);
    led_expect = data[led_width-1:0];
    @(negedge clk);
    check_seg("seg_wdata", seg_expect, seg_wdata);
    check_led("led_wdata", led_expect, led_wdata);
    // ram write leaves the display registers alone
    data = next_rand();
    write_bus(ram_addr('0, '0), data, dword_op);
    model_write('0, '0, size_dword, data);
    @(negedge clk);
    check_seg("seg_wdata", seg_expect, seg_wdata);
    check_led("led_wdata", led_expect, led_wdata);
    check_bit("wr_fault", 1'b0, wr_fault);
endtask

task automatic test_kbd_read();
    logic [63:0]          rnd;
    logic [kb_width-1:0]  kb;
    logic [reg_width-1:0] rdata;
    logic                 strobe;
    for (int i = 0; i < port_rounds; i++) begin
        rnd = next_rand();
        kb = rnd[kb_width-1:0];
        set_kbd(kb, 1'b1);
        read_bus(kbd_base, rdata, strobe);
        check_word("mem_rdata", reg_width'(kb), rdata);
        check_bit("sig_rd_kb", 1'b1, strobe);
        // not ready, the previous scancode is held
        set_kbd(rnd[15:8], 1'b0);
        read_bus(kbd_base + 64'd4, rdata, strobe);
        check_word("mem_rdata", reg_width'(kb), rdata);
        check_bit("sig_rd_kb", 1'b0, strobe);
    end
endtask

task automatic test_swt_rtc_read();
    logic [63:0]          rnd;
    logic [swt_width-1:0] swt;
    logic [reg_width-1:0] div;
    logic [reg_width-1:0] rdata;
    logic                 strobe;
    for (int i = 0; i < port_rounds; i++) begin
        rnd = next_rand();
        swt = rnd[swt_width-1:0];
        div = next_rand();
        set_misc(swt, div);
        read_bus(swt_base, rdata, strobe);
        check_word("mem_rdata", reg_width'(swt), rdata);
        read_bus(rtc_base, rdata, strobe);
        check_word("mem_rdata", div, rdata);
        // ren low keeps the counter value even as the ports move
        set_misc(~swt, next_rand());
        @(negedge clk);
        check_word("mem_rdata", div, mem_rdata);
        // mapped reads and idle cycles leave the read fault clear
        check_bit("rd_fault", 1'b0, rd_fault);
    end
endtask

task automatic test_faults();
    logic [63:0]              rnd;
    logic [swt_width-1:0]     swt;
    logic [ram_idx_width-1:0] idx;
    logic [reg_width-1:0]     data;
    logic [reg_width-1:0]     rdata;
    logic                     strobe;
    rnd = next_rand();
    swt = rnd[swt_width-1:0];
    idx = rnd[ram_idx_width+7:8];
    set_misc(swt, next_rand());
    read_bus(swt_base, rdata, strobe);
    check_word("mem_rdata", reg_width'(swt), rdata);
    read_bus(64'h0000_0000_0000_1000, rdata, strobe);
    check_word("mem_rdata", reg_width'(swt), rdata);
    @(negedge clk);
    check_bit("rd_fault", 1'b1, rd_fault);
    check_bit("wr_fault", 1'b0, wr_fault);
    data = next_rand();
    write_bus(ram_addr(idx, '0), data, dword_op);
    model_write(idx, '0, size_dword, data);
    // same doubleword index, but below the ram base
    write_bus(ram_addr(idx, '0) - ram_base, next_rand(), dword_op);
    @(negedge clk);
    check_bit("wr_fault", 1'b1, wr_fault);
    check_seg("seg_wdata", seg_expect, seg_wdata);
    check_led("led_wdata", led_expect, led_wdata);
    read_bus(ram_addr(idx, '0), rdata, strobe);
    check_word("mem_rdata", ram_model[idx], rdata);
    @(negedge clk);
    check_bit("rd_fault", 1'b1, rd_fault);
endtask

//--- test/tb_mmio.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mmio
    import mmio_pkg::*;
();

    // test sizes
    localparam int ram_slots   = 8;
    localparam int ram_writes  = 40;
    localparam int port_rounds = 4;

    // cycle budget of each test
    localparam int reset_cycles = 6;
    localparam int ram_cycles   = 2 * (2 * ram_slots + ram_writes);
    localparam int disp_cycles  = 12;
    localparam int kbd_cycles   = 6 * port_rounds;
    localparam int port_cycles  = 7 * port_rounds;
    localparam int fault_cycles = 16;
    localparam int test_cycles  = reset_cycles + ram_cycles + disp_cycles
                                + kbd_cycles + port_cycles + fault_cycles;

    // run is stopped at twice the expected length
    localparam int timeout_limit = 2 * test_cycles;

    localparam logic [size_width-1:0] dword_op = size_width'(1) << size_dword;

    logic                  clk = 1'b0;
    logic                  arst_n;
    logic [addr_width-1:0] mem_raddr;
    logic [addr_width-1:0] mem_waddr;
    logic [reg_width-1:0]  mem_wdata;
    logic                  mem_wen;
    logic                  mem_ren;
    logic [size_width-1:0] wdt_op;
    logic [reg_width-1:0]  mem_rdata;
    logic [kb_width-1:0]   kb_rdata;
    logic                  kb_ready;
    logic                  sig_rd_kb;
    logic [swt_width-1:0]  swt_rdata;
    logic [reg_width-1:0]  clkdiv;
    logic [seg_width-1:0]  seg_wdata;
    logic [led_width-1:0]  led_wdata;
    logic                  rd_fault;
    logic                  wr_fault;

    int cycle_cnt = 0;

    mmio_top UUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .mem_raddr (mem_raddr),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata),
        .mem_wen   (mem_wen),
        .mem_ren   (mem_ren),
        .wdt_op    (wdt_op),
        .mem_rdata (mem_rdata),
        .kb_rdata  (kb_rdata),
        .kb_ready  (kb_ready),
        .sig_rd_kb (sig_rd_kb),
        .swt_rdata (swt_rdata),
        .clkdiv    (clkdiv),
        .seg_wdata (seg_wdata),
        .led_wdata (led_wdata),
        .rd_fault  (rd_fault),
        .wr_fault  (wr_fault)
    );

    // 8 ns clock
    always #4 clk = ~clk;

    `include "tb_mmio_tasks.svh"

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_limit) begin
            $display("timeout: the tests did not finish within %0d cycles", timeout_limit);
            abort_run();
        end
    end

    initial begin
        arst_n    <= 1'b0;
        mem_raddr <= '0;
        mem_waddr <= '0;
        mem_wdata <= '0;
        mem_wen   <= 1'b0;
        mem_ren   <= 1'b0;
        wdt_op    <= dword_op;
        kb_rdata  <= '0;
        kb_ready  <= 1'b0;
        swt_rdata <= '0;
        clkdiv    <= '0;

        // reset held for 5 cycles
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        check_reset_state();
        test_ram_subword();
        test_seg_led();
        test_kbd_read();
        test_swt_rtc_read();
        test_faults();

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/mmio_top.sv
`timescale 1ns/1ps
`default_nettype none

module mmio_top
    import mmio_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,

    // core data side
    input  logic [addr_width-1:0] mem_raddr,
    input  logic [addr_width-1:0] mem_waddr,
    input  logic [reg_width-1:0]  mem_wdata,
    input  logic                  mem_wen,
    input  logic                  mem_ren,
    input  logic [size_width-1:0] wdt_op,
    output logic [reg_width-1:0]  mem_rdata,

    // keyboard port
    input  logic [kb_width-1:0]   kb_rdata,
    input  logic                  kb_ready,
    output logic                  sig_rd_kb,

    // switches and clock-divider counter
    input  logic [swt_width-1:0]  swt_rdata,
    input  logic [reg_width-1:0]  clkdiv,

    // display outputs
    output logic [seg_width-1:0]  seg_wdata,
    output logic [led_width-1:0]  led_wdata,

    // sticky access faults
    output logic                  rd_fault,
    output logic                  wr_fault
);

    logic [reg_width-1:0] ram_rdata;

    mem_bus_if bus ();

    // drv side of the bus comes straight from the core ports
    assign bus.raddr = mem_raddr;
    assign bus.ren   = mem_ren;
    assign bus.waddr = mem_waddr;
    assign bus.wdata = mem_wdata;
    assign bus.wen   = mem_wen;
    assign bus.size  = wdt_op;

    data_ram u_data_ram (
        .clk       (clk),
        .bus       (bus),
        .ram_rdata (ram_rdata)
    );

    periph_regs u_periph_regs (
        .clk       (clk),
        .arst_n    (arst_n),
        .bus       (bus),
        .seg_wdata (seg_wdata),
        .led_wdata (led_wdata),
        .wr_fault  (wr_fault)
    );

    read_mux u_read_mux (
        .clk       (clk),
        .arst_n    (arst_n),
        .bus       (bus),
        .ram_rdata (ram_rdata),
        .kb_rdata  (kb_rdata),
        .kb_ready  (kb_ready),
        .swt_rdata (swt_rdata),
        .clkdiv    (clkdiv),
        .mem_rdata (mem_rdata),
        .sig_rd_kb (sig_rd_kb),
        .rd_fault  (rd_fault)
    );

endmodule

`default_nettype wire

//--- verilog/periph_regs.sv
`timescale 1ns/1ps
`default_nettype none

module periph_regs
    import mmio_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    mem_bus_if.dev               bus,
    output logic [seg_width-1:0] seg_wdata,
    output logic [led_width-1:0] led_wdata,
    output logic                 wr_fault
);

    logic seg_hit;
    logic led_hit;
    logic ram_hit;
    logic unmapped;

    // write address decode
    assign seg_hit = in_region(bus.waddr, seg_base, peri_len);
    assign led_hit = in_region(bus.waddr, led_base, peri_len);
    assign ram_hit = in_region(bus.waddr, ram_base, ram_len);

    assign unmapped = !(seg_hit || led_hit || ram_hit);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            seg_wdata <= '0;
            led_wdata <= '0;
            wr_fault  <= 1'b0;
        end else if (bus.wen) begin
            if (seg_hit) begin
                seg_wdata <= bus.wdata[seg_width-1:0];
            end else if (led_hit) begin
                led_wdata <= bus.wdata[led_width-1:0];
            end else if (unmapped) begin
                // sticky until the next reset
                wr_fault <= 1'b1;
            end
            // ram hits are handled in data_ram
        end
    end

    // segment value shows up on the port one cycle after the write
    property seg_write_lands;
        @(posedge clk) disable iff (!arst_n)
            (bus.wen && seg_hit) |=> (seg_wdata == $past(bus.wdata[seg_width-1:0]));
    endproperty

    seg_write_check: assert property (seg_write_lands);

endmodule

`default_nettype wire

//--- verilog/read_mux.sv
`timescale 1ns/1ps
`default_nettype none

module read_mux
    import mmio_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    mem_bus_if.dev               bus,
    input  logic [reg_width-1:0] ram_rdata,
    input  logic [kb_width-1:0]  kb_rdata,
    input  logic                 kb_ready,
    input  logic [swt_width-1:0] swt_rdata,
    input  logic [reg_width-1:0] clkdiv,
    output logic [reg_width-1:0] mem_rdata,
    output logic                 sig_rd_kb,
    output logic                 rd_fault
);

    logic                 ram_hit;
    logic                 kbd_hit;
    logic                 swt_hit;
    logic                 rtc_hit;
    logic                 rd_valid;
    logic                 unmapped;
    logic [reg_width-1:0] last_rd;

    assign ram_hit = in_region(bus.raddr, ram_base, ram_len);
    assign kbd_hit = in_region(bus.raddr, kbd_base, kbd_len);
    assign swt_hit = in_region(bus.raddr, swt_base, peri_len);
    assign rtc_hit = in_region(bus.raddr, rtc_base, rtc_len);

    assign unmapped = bus.ren && !(ram_hit || kbd_hit || swt_hit || rtc_hit);

    // fall back to the held value unless a source answers
    always_comb begin
        mem_rdata = last_rd;
        rd_valid  = 1'b0;
        sig_rd_kb = 1'b0;
        if (bus.ren) begin
            if (ram_hit) begin
                mem_rdata = ram_rdata;
                rd_valid  = 1'b1;
            end else if (kbd_hit) begin
                // no scancode yet, core retries
                if (kb_ready) begin
                    mem_rdata = {{(reg_width-kb_width){1'b0}}, kb_rdata};
                    rd_valid  = 1'b1;
                    sig_rd_kb = 1'b1;
                end
            end else if (swt_hit) begin
                mem_rdata = {{(reg_width-swt_width){1'b0}}, swt_rdata};
                rd_valid  = 1'b1;
            end else if (rtc_hit) begin
                mem_rdata = clkdiv;
                rd_valid  = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_rd  <= '0;
            rd_fault <= 1'b0;
        end else begin
            if (rd_valid) begin
                last_rd <= mem_rdata;
            end
            if (unmapped) begin
                rd_fault <= 1'b1;
            end
        end
    end

    // keyboard pops only on a real read of a ready scancode
    kb_pop_qualified: assert property (
        @(posedge clk) disable iff (!arst_n)
            sig_rd_kb |-> (bus.ren && kb_ready)
    );

endmodule

`default_nettype wire
